// File: doc_config.svh
/*
 * Build constants for the DOC5503 style wavetable engine.
 * Include wherever oscillator arrays are sized, slot timing is
 * counted, the frame mix is scaled or the host map is decoded.
 */
`ifndef DOC_CONFIG_SVH
`define DOC_CONFIG_SVH

// Oscillator array depth
`define DOC_NUM_OSC 32

// clk_en_i pulses per oscillator slot
`define DOC_SLOT_TICKS 8

// Frame sum width and output scaling
`define DOC_MIX_WIDTH 24
`define DOC_MIX_SHIFT 3          // Arithmetic shift down to the 16-bit sample

// Host register map
`define DOC_ADDR_LAST_OSC_REG 8'hDF  // Top of per-oscillator window
`define DOC_ADDR_OSC_EN 8'hE1        // Oscillator enable register

`endif

// File: doc_pkg.sv
/*
 * Shared types for the wavetable engine.
 * Modules refer to these by scoped name. The control and
 * resolution/table-size bytes are unions, since the host sees a raw
 * byte and the engine sees fields.
 */
package doc_pkg;

    typedef logic [4:0]         osc_idx_t;    // Oscillator 0..31
    typedef logic [7:0]         reg_byte_t;
    typedef logic [23:0]        acc_t;        // Phase accumulator
    typedef logic [15:0]        wave_addr_t;
    typedef logic signed [15:0] mix_t;
    typedef logic [2:0]         reg_group_t;  // Host address bits 7:5

    // Control register, $A0-BF
    typedef union packed {
        reg_byte_t raw;                       // Host view
        struct packed {
            logic [3:0] chan;                 // Channel assign, not routed
            logic       spare;
            logic [1:0] mode;                 // 01 one-shot, others free-run
            logic       halt;
        } f;
    } osc_control_u;

    // Resolution/table size register, $C0-DF
    typedef union packed {
        reg_byte_t raw;
        struct packed {
            logic [1:0] spare;
            logic [2:0] size;                 // Table size, 256 << size bytes
            logic [2:0] res;                  // Address resolution
        } f;
    } res_size_u;

endpackage

// File: doc_register_file.sv
/*
 * Per-oscillator register arrays and accumulators.
 * The host port reads and writes $00-DF and the enable register at $E1.
 * The engine port latches one oscillator's entries on eng_load_i and
 * takes sample, halt and accumulator write-backs.
 */
`include "doc_config.svh"

module doc_register_file (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  logic                  clear_i,
    input  doc_pkg::osc_idx_t     clear_idx_i,
    input  logic                  cs_n_i,
    input  logic                  we_n_i,
    input  doc_pkg::reg_byte_t    addr_i,
    input  doc_pkg::reg_byte_t    data_i,
    output doc_pkg::reg_byte_t    data_o,
    input  doc_pkg::osc_idx_t     eng_idx_i,
    input  logic                  eng_load_i,
    input  logic                  sample_we_i,
    input  logic                  halt_we_i,
    input  logic                  acc_we_i,
    input  doc_pkg::reg_byte_t    sample_i,
    input  doc_pkg::acc_t         acc_i,
    output logic [15:0]           freq_o,
    output doc_pkg::reg_byte_t    vol_o,
    output doc_pkg::reg_byte_t    wtp_o,
    output doc_pkg::osc_control_u control_o,
    output doc_pkg::res_size_u    rts_o,
    output doc_pkg::acc_t         acc_o,
    output doc_pkg::osc_idx_t     osc_last_o
);
    doc_pkg::reg_byte_t    fl_r  [`DOC_NUM_OSC];  // $00-1F
    doc_pkg::reg_byte_t    fh_r  [`DOC_NUM_OSC];  // $20-3F
    doc_pkg::reg_byte_t    vol_r [`DOC_NUM_OSC];  // $40-5F
    doc_pkg::reg_byte_t    wds_r [`DOC_NUM_OSC];  // $60-7F, last sample
    doc_pkg::reg_byte_t    wtp_r [`DOC_NUM_OSC];  // $80-9F
    doc_pkg::osc_control_u ctl_r [`DOC_NUM_OSC];  // $A0-BF
    doc_pkg::res_size_u    rts_r [`DOC_NUM_OSC];  // $C0-DF
    doc_pkg::acc_t         acc_r [`DOC_NUM_OSC];
    doc_pkg::reg_byte_t    osc_en_r;               // $E1

    doc_pkg::osc_idx_t  host_idx;
    doc_pkg::reg_group_t host_grp;
    logic               host_wr;
    logic               host_rd;
    logic               in_window;
    doc_pkg::reg_byte_t rd_data;

    assign host_idx   = addr_i[4:0];
    assign host_grp   = addr_i[7:5];
    assign host_wr    = !cs_n_i && !we_n_i;
    assign host_rd    = !cs_n_i && we_n_i;
    assign in_window  = (addr_i <= `DOC_ADDR_LAST_OSC_REG);
    assign osc_last_o = osc_en_r[5:1];  // Enabled count minus one

    // Host read mux, anything unmapped reads zero
    always_comb begin
        rd_data = '0;
        if (in_window) begin
            case (host_grp)
                3'd0:    rd_data = fl_r[host_idx];
                3'd1:    rd_data = fh_r[host_idx];
                3'd2:    rd_data = vol_r[host_idx];
                3'd3:    rd_data = wds_r[host_idx];
                3'd4:    rd_data = wtp_r[host_idx];
                3'd5:    rd_data = ctl_r[host_idx].raw;
                3'd6:    rd_data = rts_r[host_idx].raw;
                default: rd_data = '0;
            endcase
        end else if (addr_i == `DOC_ADDR_OSC_EN) begin
            rd_data = osc_en_r;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            osc_en_r <= '0;  // One oscillator after reset
            data_o   <= '0;
        end else begin
            if (host_wr && addr_i == `DOC_ADDR_OSC_EN) osc_en_r <= data_i;
            if (host_rd) data_o <= rd_data;  // Visible the clock after the read
        end
    end

    // Array writes, clear sweep first, then host, then engine
    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            fl_r[clear_idx_i]  <= '0;
            fh_r[clear_idx_i]  <= '0;
            vol_r[clear_idx_i] <= '0;
            wds_r[clear_idx_i] <= '0;
            wtp_r[clear_idx_i] <= '0;
            ctl_r[clear_idx_i] <= '0;  // Not halted
            rts_r[clear_idx_i] <= '0;
            acc_r[clear_idx_i] <= '0;
        end else begin
            if (host_wr && in_window) begin
                case (host_grp)
                    3'd0:    fl_r[host_idx] <= data_i;
                    3'd1:    fh_r[host_idx] <= data_i;
                    3'd2:    vol_r[host_idx] <= data_i;
                    3'd3:    wds_r[host_idx] <= data_i;
                    3'd4:    wtp_r[host_idx] <= data_i;
                    3'd5:    ctl_r[host_idx].raw <= data_i;
                    3'd6:    rts_r[host_idx].raw <= data_i;
                    default: ;
                endcase
            end
            // Engine write-backs come last and so win a same-entry collision
            if (sample_we_i) wds_r[eng_idx_i] <= sample_i;
            if (halt_we_i) ctl_r[eng_idx_i].f.halt <= 1'b1;
            if (acc_we_i) acc_r[eng_idx_i] <= acc_i;
        end
    end

    // Current oscillator snapshot for the datapath
    always_ff @(posedge clk_i) begin
        if (eng_load_i) begin
            freq_o    <= {fh_r[eng_idx_i], fl_r[eng_idx_i]};
            vol_o     <= vol_r[eng_idx_i];
            wtp_o     <= wtp_r[eng_idx_i];
            control_o <= ctl_r[eng_idx_i];
            rts_o     <= rts_r[eng_idx_i];
            acc_o     <= acc_r[eng_idx_i];
        end
    end

    // The clear sweep runs before the host may touch the part
    assert property (@(posedge clk_i) disable iff (!reset_n_i) !(clear_i && host_wr));

endmodule

// File: doc_sequencer.sv
/*
 * Engine control FSM.
 * Clears the register file after reset, then walks the enabled
 * oscillators one per slot of clk_en_i ticks. Each turn loads, fetches
 * a wave byte over the strobe/ready port, mixes and advances, and a
 * refresh slot closes the frame.
 */
`include "doc_config.svh"

module doc_sequencer (
    input  logic               clk_i,
    input  logic               reset_n_i,
    input  logic               clk_en_i,
    input  logic               wave_data_ready_i,
    input  doc_pkg::reg_byte_t wave_data_i,
    input  doc_pkg::osc_idx_t  osc_last_i,
    input  logic               halted_i,
    input  logic               overflow_i,    // One-shot overflow from the oscillator
    output logic               clear_o,
    output doc_pkg::osc_idx_t  clear_idx_o,
    output doc_pkg::osc_idx_t  eng_idx_o,
    output logic               eng_load_o,
    output logic               sample_we_o,
    output doc_pkg::reg_byte_t sample_o,
    output logic               halt_we_o,
    output logic               addr_en_o,
    output logic               mix_add_o,
    output logic               acc_step_o,
    output logic               frame_end_o,
    output logic               wave_rd_o
);
    localparam int TICK_W = $clog2(`DOC_SLOT_TICKS);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`DOC_SLOT_TICKS - 1);
    localparam doc_pkg::osc_idx_t CLEAR_LAST = doc_pkg::osc_idx_t'(`DOC_NUM_OSC - 1);

    localparam logic [3:0] S_CLEAR   = 4'd0;
    localparam logic [3:0] S_IDLE    = 4'd1;
    localparam logic [3:0] S_LOAD    = 4'd2;  // Register file snapshot
    localparam logic [3:0] S_ADDR    = 4'd3;  // Halt check and address latch
    localparam logic [3:0] S_READ    = 4'd4;  // Fetch strobe
    localparam logic [3:0] S_WAIT    = 4'd5;
    localparam logic [3:0] S_STORE   = 4'd6;  // Sample write-back
    localparam logic [3:0] S_MIX     = 4'd7;
    localparam logic [3:0] S_ACC     = 4'd8;
    localparam logic [3:0] S_REFRESH = 4'd9;

    logic [3:0]         state_r;
    logic [TICK_W-1:0]  tick_r;
    doc_pkg::osc_idx_t  idx_r;
    doc_pkg::osc_idx_t  clr_idx_r;
    doc_pkg::reg_byte_t sample_r;
    logic               refresh_r;  // Scan done, next slot refreshes
    logic               slot_start;
    logic               zero_byte;
    logic               turn_end;

    assign slot_start = clk_en_i && (tick_r == TICK_LAST);
    assign zero_byte  = (sample_r == 8'h00);
    // Halted at load, zero byte, or accumulator stored
    assign turn_end   = (state_r == S_ADDR && halted_i) ||
                        (state_r == S_STORE && zero_byte) ||
                        (state_r == S_ACC);

    // Slot tick counter, runs in every phase
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            tick_r <= '0;
        end else if (clk_en_i) begin
            tick_r <= tick_r + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            state_r   <= S_CLEAR;
            clr_idx_r <= '0;
            idx_r     <= '0;
            refresh_r <= 1'b0;
        end else begin
            case (state_r)
                S_CLEAR: begin
                    clr_idx_r <= clr_idx_r + 1'b1;
                    if (clr_idx_r == CLEAR_LAST) state_r <= S_IDLE;
                end
                S_IDLE: begin
                    // Slot starts are only taken here, busy slots are skipped
                    if (slot_start) state_r <= refresh_r ? S_REFRESH : S_LOAD;
                end
                S_LOAD:  state_r <= S_ADDR;
                S_ADDR:  state_r <= halted_i ? S_IDLE : S_READ;
                S_READ:  state_r <= S_WAIT;
                S_WAIT: begin
                    if (wave_data_ready_i) state_r <= S_STORE;  // No timeout
                end
                S_STORE: state_r <= zero_byte ? S_IDLE : S_MIX;
                S_MIX:   state_r <= S_ACC;
                S_ACC:   state_r <= S_IDLE;
                S_REFRESH: begin
                    refresh_r <= 1'b0;
                    idx_r     <= '0;
                    state_r   <= S_IDLE;
                end
                default: state_r <= S_IDLE;
            endcase

            if (turn_end) begin
                if (idx_r >= osc_last_i) refresh_r <= 1'b1;  // Enable may shrink mid-frame
                else idx_r <= idx_r + 1'b1;
            end
        end
    end

    // Fetched byte held for write-back and mix
    always_ff @(posedge clk_i) begin
        if (state_r == S_WAIT && wave_data_ready_i) sample_r <= wave_data_i;
    end

    assign clear_o     = (state_r == S_CLEAR);
    assign clear_idx_o = clr_idx_r;
    assign eng_idx_o   = idx_r;
    assign eng_load_o  = (state_r == S_LOAD);
    assign addr_en_o   = (state_r == S_ADDR) && !halted_i;
    assign wave_rd_o   = (state_r == S_READ);
    assign sample_we_o = (state_r == S_STORE);
    assign sample_o    = sample_r;
    assign halt_we_o   = (state_r == S_STORE && zero_byte) ||
                         (state_r == S_ACC && overflow_i);
    assign mix_add_o   = (state_r == S_MIX);
    assign acc_step_o  = (state_r == S_ACC);
    assign frame_end_o = (state_r == S_REFRESH);

    // One fetch outstanding at a time
    assert property (@(posedge clk_i) disable iff (!reset_n_i)
        wave_rd_o |=> (!wave_rd_o until_with wave_data_ready_i));

endmodule

// File: doc_oscillator.sv
/*
 * Datapath for the oscillator in the current slot.
 * Latches the wave-table address on addr_en_i and, on acc_step_i,
 * offers the advanced accumulator for write-back. One-shot overflow
 * is reported so the sequencer can halt the oscillator.
 */
module doc_oscillator (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  logic                  addr_en_i,
    input  logic                  acc_step_i,
    input  logic [15:0]           freq_i,
    input  doc_pkg::acc_t         acc_i,
    input  doc_pkg::reg_byte_t    wtp_i,
    input  doc_pkg::osc_control_u control_i,
    input  doc_pkg::res_size_u    rts_i,
    output doc_pkg::wave_addr_t   wave_address_o,
    output doc_pkg::acc_t         acc_o,
    output logic                  acc_we_o,
    output logic                  halted_o,
    output logic                  overflow_o
);
    localparam logic [1:0] MODE_ONE_SHOT = 2'b01;  // 00, 10, 11 run free

    logic [4:0]          shift;      // 2..16
    logic [4:0]          top_bit;    // Overflow bit, 17..24
    doc_pkg::reg_byte_t  ptr_mask;
    doc_pkg::wave_addr_t addr_next;
    logic [24:0]         sum;        // Carry kept for resolution 7
    logic [24:0]         wrap_mask;
    logic                overflow;
    logic                one_shot;

    // Wave address, accumulator window ORed with the table page
    assign shift     = 5'd9 + 5'(rts_i.f.res) - 5'(rts_i.f.size);
    assign ptr_mask  = 8'hFF << rts_i.f.size;  // Low size bits belong to the offset
    assign addr_next = doc_pkg::wave_addr_t'(acc_i >> shift) | {wtp_i & ptr_mask, 8'h00};

    // Accumulator advance and wrap
    assign top_bit   = 5'd17 + 5'(rts_i.f.res);
    assign sum       = {1'b0, acc_i} + {9'd0, freq_i};
    assign wrap_mask = (25'd1 << top_bit) - 25'd1;
    assign overflow  = sum[top_bit];
    assign one_shot  = (control_i.f.mode == MODE_ONE_SHOT);

    assign acc_o      = (overflow && one_shot) ? '0 : sum[23:0] & wrap_mask[23:0];
    assign acc_we_o   = acc_step_i;
    assign overflow_o = acc_step_i && overflow && one_shot;
    assign halted_o   = control_i.f.halt;

    // Address held steady across the fetch
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            wave_address_o <= '0;
        end else if (addr_en_i) begin
            wave_address_o <= addr_next;
        end
    end

endmodule

// File: doc_mixer.sv
/*
 * Frame mono mix.
 * Each mix_add_i adds sample times volume into a wide signed sum.
 * frame_end_i scales the sum down, saturates it onto mono_mix_o and
 * starts the next frame from zero.
 */
`include "doc_config.svh"

module doc_mixer (
    input  logic               clk_i,
    input  logic               reset_n_i,
    input  logic               mix_add_i,
    input  logic               frame_end_i,
    input  doc_pkg::reg_byte_t sample_i,
    input  doc_pkg::reg_byte_t vol_i,
    output doc_pkg::mix_t      mono_mix_o
);
    localparam int W = `DOC_MIX_WIDTH;
    localparam logic signed [W-1:0] POS_LIMIT = W'(32767);
    localparam logic signed [W-1:0] NEG_LIMIT = -W'(32768);

    logic signed [7:0]   sample_s;
    logic signed [8:0]   vol_s;
    logic signed [16:0]  product;
    logic signed [W-1:0] product_ext;
    logic signed [W-1:0] sum_r;
    logic signed [W-1:0] scaled;

    assign sample_s    = {~sample_i[7], sample_i[6:0]};  // $80 is silence
    assign vol_s       = {1'b0, vol_i};                  // Volume is unsigned
    assign product     = sample_s * vol_s;
    assign product_ext = product;                        // Sign extend
    assign scaled      = sum_r >>> `DOC_MIX_SHIFT;

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            sum_r      <= '0;
            mono_mix_o <= '0;
        end else if (frame_end_i) begin
            sum_r <= '0;
            if (scaled > POS_LIMIT) mono_mix_o <= 16'sh7FFF;
            else if (scaled < NEG_LIMIT) mono_mix_o <= 16'sh8000;
            else mono_mix_o <= scaled[15:0];
        end else if (mix_add_i) begin
            sum_r <= sum_r + product_ext;
        end
    end

endmodule

// File: doc5503_core.sv
/*
 * Top level of the wavetable engine.
 * Connects the sequencer to the register file, oscillator datapath
 * and mixer, and exposes the host bus, the wave-memory port and the
 * mono output.
 */
module doc5503_core (
    input  logic                clk_i,
    input  logic                reset_n_i,
    input  logic                clk_en_i,
    input  logic                cs_n_i,
    input  logic                we_n_i,
    input  doc_pkg::reg_byte_t  addr_i,
    input  doc_pkg::reg_byte_t  data_i,
    output doc_pkg::reg_byte_t  data_o,
    output doc_pkg::wave_addr_t wave_address_o,
    output logic                wave_rd_o,
    input  logic                wave_data_ready_i,
    input  doc_pkg::reg_byte_t  wave_data_i,
    output doc_pkg::mix_t       mono_mix_o
);
    logic                  clear;
    doc_pkg::osc_idx_t     clear_idx;
    doc_pkg::osc_idx_t     eng_idx;
    doc_pkg::osc_idx_t     osc_last;
    logic                  eng_load;
    logic                  sample_we;
    logic                  halt_we;
    logic                  acc_we;
    logic                  addr_en;
    logic                  mix_add;
    logic                  acc_step;
    logic                  frame_end;
    logic                  halted;
    logic                  overflow;
    doc_pkg::reg_byte_t    sample;
    logic [15:0]           freq;
    doc_pkg::reg_byte_t    vol;
    doc_pkg::reg_byte_t    wtp;
    doc_pkg::osc_control_u control;
    doc_pkg::res_size_u    rts;
    doc_pkg::acc_t         acc_cur;   // Snapshot from the register file
    doc_pkg::acc_t         acc_next;  // Advanced value for write-back

    doc_sequencer u_seq (
        .clk_i, .reset_n_i, .clk_en_i, .wave_data_ready_i, .wave_data_i,
        .osc_last_i(osc_last), .halted_i(halted), .overflow_i(overflow),
        .clear_o(clear), .clear_idx_o(clear_idx), .eng_idx_o(eng_idx),
        .eng_load_o(eng_load), .sample_we_o(sample_we), .sample_o(sample),
        .halt_we_o(halt_we), .addr_en_o(addr_en), .mix_add_o(mix_add),
        .acc_step_o(acc_step), .frame_end_o(frame_end), .wave_rd_o
    );

    doc_register_file u_regs (
        .clk_i, .reset_n_i, .clear_i(clear), .clear_idx_i(clear_idx),
        .cs_n_i, .we_n_i, .addr_i, .data_i, .data_o,
        .eng_idx_i(eng_idx), .eng_load_i(eng_load), .sample_we_i(sample_we),
        .halt_we_i(halt_we), .acc_we_i(acc_we), .sample_i(sample), .acc_i(acc_next),
        .freq_o(freq), .vol_o(vol), .wtp_o(wtp), .control_o(control),
        .rts_o(rts), .acc_o(acc_cur), .osc_last_o(osc_last)
    );

    doc_oscillator u_osc (
        .clk_i, .reset_n_i, .addr_en_i(addr_en), .acc_step_i(acc_step),
        .freq_i(freq), .acc_i(acc_cur), .wtp_i(wtp), .control_i(control),
        .rts_i(rts), .wave_address_o, .acc_o(acc_next), .acc_we_o(acc_we),
        .halted_o(halted), .overflow_o(overflow)
    );

    doc_mixer u_mix (
        .clk_i, .reset_n_i, .mix_add_i(mix_add), .frame_end_i(frame_end),
        .sample_i(sample), .vol_i(vol), .mono_mix_o
    );

endmodule

// File: tb_doc5503.sv
/*
 * Testbench for the DOC5503 style wavetable engine.
 * A table of cases is applied in a loop. Each case resets the DUT, loads
 * the wave-memory model, programs oscillators over the host bus and checks
 * readbacks, fetch addresses, halts and the mono mix against a model.
 */
`include "doc_config.svh"

module tb_doc5503;
    localparam int NCASE = 7;
    localparam int K_REGS = 0, K_ADDR = 1, K_MONO = 2;  // Case kinds

    logic clk_i, reset_n_i, clk_en_i, cs_n_i, we_n_i, wave_rd_o, wave_data_ready_i;
    doc_pkg::reg_byte_t  addr_i, data_i, data_o, wave_data_i;
    doc_pkg::wave_addr_t wave_address_o;
    doc_pkg::mix_t       mono_mix_o;

    doc_pkg::reg_byte_t  wave_mem [65536];
    doc_pkg::wave_addr_t rd_q[$];               // Addresses seen on wave_rd_o
    doc_pkg::wave_addr_t exp_q[$];              // Model address sequence
    bit                  exp_halt;
    logic [31:0]         lcg_state = 32'h17cf;
    int                  err_val = 0, err_other = 0;

    // Stimulus and expected-value table
    string               c_name [NCASE];
    int                  c_kind [NCASE], c_nrd [NCASE];
    logic [15:0]         c_freq [NCASE], c_a0 [NCASE], c_a1 [NCASE];
    doc_pkg::reg_byte_t  c_wtp0 [NCASE], c_wtp1 [NCASE], c_rts [NCASE], c_mode [NCASE];
    doc_pkg::reg_byte_t  c_vol0 [NCASE], c_vol1 [NCASE], c_d0 [NCASE], c_d1 [NCASE];

    doc5503_core doc5503_core_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // clk_en_i every 4th clock
    initial begin : en_gen
        int n;
        n = 0;
        forever begin
            @(negedge clk_i);
            n++;
            clk_en_i = (n % 4 == 0);
        end
    end

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    // Wave memory, answers each fetch 1..6 cycles after the strobe
    initial begin : mem_model
        doc_pkg::wave_addr_t a;
        int d;
        forever begin
            @(negedge clk_i);
            wave_data_ready_i = 1'b0;
            if (wave_rd_o) begin
                a = wave_address_o;
                rd_q.push_back(a);
                d = 1 + lcg_next() % 6;
                repeat (d) @(negedge clk_i);
                wave_data_i       = wave_mem[a];
                wave_data_ready_i = 1'b1;
            end
        end
    end

    task automatic set_case(input int i, input string nm, input int k, input logic [15:0] f,
                            input doc_pkg::reg_byte_t w0, w1, r, m, v0, v1,
                            input int n, input logic [15:0] a0, a1,
                            input doc_pkg::reg_byte_t d0, d1);
        c_name[i] = nm;
        c_kind[i] = k;
        c_freq[i] = f;
        c_wtp0[i] = w0;
        c_wtp1[i] = w1;
        c_rts[i]  = r;
        c_mode[i] = m;
        c_vol0[i] = v0;
        c_vol1[i] = v1;
        c_nrd[i]  = n;
        c_a0[i]   = a0;
        c_a1[i]   = a1;
        c_d0[i]   = d0;
        c_d1[i]   = d1;
    endtask

    task automatic check_byte(input string nm, input doc_pkg::reg_byte_t e, a);
        if (e !== a) begin
            $display("[ERROR] %s expected %02h actual %02h", nm, e, a);
            err_val++;
        end
    endtask

    task automatic check_addr(input string nm, input doc_pkg::wave_addr_t e, a);
        if (e !== a) begin
            $display("[ERROR] %s expected %04h actual %04h", nm, e, a);
            err_val++;
        end
    endtask

    task automatic check_mix(input string nm, input doc_pkg::mix_t e, a);
        if (e !== a) begin
            $display("[ERROR] %s expected %0d actual %0d", nm, e, a);
            err_val++;
        end
    endtask

    task automatic host_write(input doc_pkg::reg_byte_t a, d);
        @(negedge clk_i);
        cs_n_i = 1'b0;
        we_n_i = 1'b0;
        addr_i = a;
        data_i = d;
        @(negedge clk_i);
        cs_n_i = 1'b1;
        we_n_i = 1'b1;
    endtask

    task automatic host_read(input doc_pkg::reg_byte_t a, output doc_pkg::reg_byte_t d);
        @(negedge clk_i);
        cs_n_i = 1'b0;
        we_n_i = 1'b1;
        addr_i = a;
        @(negedge clk_i);
        cs_n_i = 1'b1;
        d = data_o;                             // Registered on the edge between
    endtask

    task automatic reset_dut();
        reset_n_i = 1'b0;
        repeat (10) @(negedge clk_i);
        reset_n_i = 1'b1;
        repeat (40) @(negedge clk_i);           // Clear sweep takes 32 cycles
    endtask

    task automatic wait_reads(input string nm, input int n);
        int t;
        t = 0;
        while (rd_q.size() < n && t < 4000) begin
            @(negedge clk_i);
            t++;
        end
        if (rd_q.size() < n) begin
            $display("%s: timed out waiting for wave fetch %0d", nm, n);
            err_other++;
        end
    endtask

    // Free-running or one-shot walk of the accumulator, stops at a halt
    task automatic build_expected(input int c);
        doc_pkg::acc_t       acc;
        logic [24:0]         sum;
        int                  sh, top;
        doc_pkg::reg_byte_t  pm;
        doc_pkg::wave_addr_t a;
        exp_q.delete();
        exp_halt = 0;
        acc = '0;
        sh  = 9 + c_rts[c][2:0] - c_rts[c][5:3];
        top = 17 + c_rts[c][2:0];
        pm  = 8'hFF << c_rts[c][5:3];
        while (exp_q.size() < c_nrd[c] && !exp_halt) begin
            a = 16'(acc >> sh) | {c_wtp0[c] & pm, 8'h00};
            exp_q.push_back(a);
            if (wave_mem[a] == 8'h00) begin
                exp_halt = 1;                   // Zero byte, no advance
            end else begin
                sum = acc + c_freq[c];
                if (sum[top] && c_mode[c] == 8'd1) begin
                    exp_halt = 1;
                    acc = '0;
                end else begin
                    acc = 24'(sum & ((25'd1 << top) - 1));
                end
            end
        end
    endtask

    function automatic doc_pkg::mix_t mono_model(input int c);
        int s;
        s = (int'(c_d0[c]) - 128) * int'(c_vol0[c]) + (int'(c_d1[c]) - 128) * int'(c_vol1[c]);
        s = s >>> `DOC_MIX_SHIFT;
        if (s > 32767) s = 32767;
        if (s < -32768) s = -32768;
        return doc_pkg::mix_t'(s);
    endfunction

    // Halts the oscillator first so it sits still while programmed
    task automatic program_osc(input int i, input int c, input doc_pkg::reg_byte_t wtp, vol);
        host_write(8'(8'hA0 + i), 8'h01);
        host_write(8'(8'h00 + i), c_freq[c][7:0]);
        host_write(8'(8'h20 + i), c_freq[c][15:8]);
        host_write(8'(8'h40 + i), vol);
        host_write(8'(8'h80 + i), wtp);
        host_write(8'(8'hC0 + i), c_rts[c]);
    endtask

    initial begin : main
        doc_pkg::reg_byte_t  rd, ctl_run;
        doc_pkg::wave_addr_t base;
        int                  k, t;
        cs_n_i            = 1'b1;
        we_n_i            = 1'b1;
        addr_i            = '0;
        data_i            = '0;
        reset_n_i         = 1'b0;
        clk_en_i          = 1'b0;
        wave_data_ready_i = 1'b0;
        wave_data_i       = '0;
        // name kind freq wtp0 wtp1 rts mode vol0 vol1 reads a0 a1 d0 d1
        set_case(0, "reg_readback", K_REGS, 0, 0, 0, 0, 0, 0, 0, 0, 16'hFFFF, 16'hFFFF, 0, 0);
        set_case(1, "addr_sweep", K_ADDR, 16'h1234, 8'h37, 0, 8'h13, 0, 8'h40, 0, 12,
                 16'hFFFF, 16'hFFFF, 0, 0);
        set_case(2, "mono_two_osc", K_MONO, 0, 8'h20, 8'h21, 0, 0, 8'd200, 8'd100, 0,
                 16'h2000, 16'h2100, 8'hF0, 8'hC0);
        set_case(3, "mono_zero_vol", K_MONO, 0, 8'h20, 8'h21, 0, 0, 8'd0, 8'd100, 0,
                 16'h2000, 16'h2100, 8'hF0, 8'h30);
        set_case(4, "zero_byte_halt", K_ADDR, 0, 8'h10, 0, 0, 0, 8'h40, 0, 4,
                 16'h1000, 16'hFFFF, 8'h00, 0);
        set_case(5, "one_shot_wrap", K_ADDR, 16'h4000, 8'h05, 0, 0, 8'd1, 8'h40, 0, 12,
                 16'hFFFF, 16'hFFFF, 0, 0);
        set_case(6, "free_run_wrap", K_ADDR, 16'h4000, 8'h05, 0, 0, 8'd0, 8'h40, 0, 12,
                 16'hFFFF, 16'hFFFF, 0, 0);

        for (int c = 0; c < NCASE; c++) begin
            for (int a = 0; a < 65536; a++) begin
                wave_mem[a] = (8'(a >> 8) ^ 8'(a)) | 8'h01;  // Never zero by default
            end
            if (c_a0[c] != 16'hFFFF) wave_mem[c_a0[c]] = c_d0[c];
            if (c_a1[c] != 16'hFFFF) wave_mem[c_a1[c]] = c_d1[c];
            reset_dut();
            ctl_run = c_mode[c] << 1;           // Mode field, halt clear
            if (c_kind[c] == K_REGS) begin
                for (int g = 0; g < 7; g++) host_write(8'(g * 32 + 5), 8'(8'h1D + g * 8'h22));
                for (int g = 0; g < 7; g++) begin
                    host_read(8'(g * 32 + 5), rd);
                    check_byte(c_name[c], 8'(8'h1D + g * 8'h22), rd);
                end
                host_write(`DOC_ADDR_OSC_EN, 8'h0A);
                host_read(`DOC_ADDR_OSC_EN, rd);
                check_byte(c_name[c], 8'h0A, rd);
                host_write(8'hE0, 8'h5A);       // Unmapped, must stay zero
                host_read(8'hE0, rd);
                check_byte(c_name[c], 8'h00, rd);
                host_read(8'hE2, rd);
                check_byte(c_name[c], 8'h00, rd);
                host_read(8'hFF, rd);
                check_byte(c_name[c], 8'h00, rd);
            end else if (c_kind[c] == K_MONO) begin
                program_osc(0, c, c_wtp0[c], c_vol0[c]);
                program_osc(1, c, c_wtp1[c], c_vol1[c]);
                host_write(`DOC_ADDR_OSC_EN, 8'h02);  // Two oscillators
                host_write(8'hA0, ctl_run);
                host_write(8'hA1, ctl_run);
                t = 0;
                while (mono_mix_o !== mono_model(c) && t < 2000) begin
                    @(negedge clk_i);
                    t++;
                end
                check_mix(c_name[c], mono_model(c), mono_mix_o);
            end else begin
                build_expected(c);
                program_osc(0, c, c_wtp0[c], c_vol0[c]);
                rd_q.delete();
                host_write(8'hA0, ctl_run);
                wait_reads(c_name[c], exp_q.size());
                foreach (exp_q[i]) begin
                    if (i < rd_q.size()) check_addr(c_name[c], exp_q[i], rd_q[i]);
                end
                if (exp_halt) begin
                    t = 0;
                    rd = '0;
                    while (!rd[0] && t < 100) begin
                        host_read(8'hA0, rd);
                        t++;
                    end
                    check_byte(c_name[c], ctl_run | 8'h01, rd);
                    k = rd_q.size();
                    repeat (200) @(negedge clk_i);  // Several frames of one oscillator
                    if (rd_q.size() != k) begin
                        $display("%s: halted oscillator kept fetching", c_name[c]);
                        err_other++;
                    end
                    // Restart, accumulator must be back at zero
                    base = {c_wtp0[c] & (8'hFF << c_rts[c][5:3]), 8'h00};
                    host_write(8'hA0, ctl_run);
                    wait_reads(c_name[c], k + 1);
                    if (rd_q.size() > k) check_addr(c_name[c], base, rd_q[k]);
                end
            end
        end

        $display("Errors: %0d value mismatches, %0d other failures", err_val, err_other);
        if (err_val == 0 && err_other == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
doc_pkg.sv
doc_register_file.sv
doc_sequencer.sv
doc_oscillator.sv
doc_mixer.sv
doc5503_core.sv
tb_doc5503.sv
